// ==== hw/burst_sequencer.sv ====
`timescale 1ns/1ps

module burst_sequencer #(
   parameter int READ_BURST_LEN = 8             // words per read burst, 1 to 64
) (
   input  logic                wb_clk,
   input  logic                mem_rst,
   input  logic                p0_rd_empty_i,
   input  logic                p0_cmd_full_i,
   input  logic                p0_wr_full_i,
   output logic                p0_cmd_en_o,
   output mem_pkg::mcb_instr_e p0_cmd_instr_o,
   output mem_pkg::blen_t      p0_cmd_bl_o,
   output mem_pkg::addr_t      p0_cmd_addr_o,   // burst start address
   wb_req_if.seq               req,
   rd_ctl_if.seq               rd
);

   typedef enum logic [2:0] {
      ST_RST,
      ST_IDLE,
      ST_WR_FIFO,
      ST_WR_CMD,
      ST_RD_FIFO,
      ST_RD_CMD
   } seq_state_e;

   localparam mem_pkg::cnt_t  RD_WORDS = mem_pkg::cnt_t'(READ_BURST_LEN);
   localparam mem_pkg::blen_t RD_BLEN  = mem_pkg::blen_t'(READ_BURST_LEN - 1);

   seq_state_e     state;
   mem_pkg::addr_t adr_next;   // address of the next word in the read fifo
   mem_pkg::cnt_t  rd_left;    // words still due from issued bursts
   logic           cmd_issue;
   logic           start;
   logic           rd_hit;
   logic           wr_close;
   logic           owed;
   logic           rd_more;

   //////////////////////////////////////////////////
   // decisions of this cycle
   //////////////////////////////////////////////////

   // commands leave only from the two wait states, gated by full
   assign cmd_issue   = ((state == ST_WR_CMD) | (state == ST_RD_CMD)) & ~p0_cmd_full_i;
   assign p0_cmd_en_o = cmd_issue;

   // a strobe in ST_WR_CMD implies cmd fifo not full, so the write goes out now
   assign start    = req.acc & ((state == ST_IDLE) | (state == ST_WR_CMD));
   assign rd_hit   = (req.addr == adr_next) & (rd_left != '0) & ~rd.invld;
   assign wr_close = (state == ST_WR_FIFO) & (p0_wr_full_i | ~req.cyc);
   assign owed     = req.cyc & ((rd.ack_cnt < req.stb_cnt) | req.acc);
   assign rd_more  = (state == ST_RD_FIFO) & owed & (rd_left != '0);

   assign rd.deliver  = ~p0_rd_empty_i & ~rd.invld & ((start & ~req.we & rd_hit) | rd_more);
   // writes always flush read-ahead, a read miss only when no drain is running
   assign rd.inv_load = wr_close | (start & ~req.we & ~rd_hit & ~rd.invld);
   assign rd.inv_val  = rd_left;
   assign req.clr_cnt = (state == ST_IDLE) | ((state == ST_WR_CMD) & cmd_issue);

   //////////////////////////////////////////////////
   // fsm
   //////////////////////////////////////////////////

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         state   <= ST_RST;
         rd_left <= '0;
      end else begin
         case (state)
            ST_RST: begin
               if (!req.cyc) begin                  // let a running cycle end first
                  state <= ST_IDLE;
               end
            end
            ST_IDLE, ST_WR_CMD: begin
               if (cmd_issue) begin
                  state <= ST_IDLE;                 // write burst handed over
               end
               if (start) begin
                  p0_cmd_addr_o <= req.addr;
                  if (req.we) begin
                     state <= ST_WR_FIFO;
                  end else if (rd_hit) begin
                     // served from read-ahead, maybe right now
                     if (rd.deliver) begin
                        rd_left  <= rd_left - 1'b1;
                        adr_next <= adr_next + mem_pkg::ADDR_STEP;
                     end
                     state <= ST_RD_FIFO;
                  end else begin
                     p0_cmd_instr_o <= mem_pkg::MCB_RD_AP;
                     p0_cmd_bl_o    <= RD_BLEN;
                     adr_next       <= req.addr;    // first word after the drain
                     rd_left        <= RD_WORDS;
                     state          <= ST_RD_CMD;
                  end
               end
            end
            ST_WR_FIFO: begin
               if (wr_close) begin
                  p0_cmd_instr_o <= mem_pkg::MCB_WR_AP;
                  p0_cmd_bl_o    <= mem_pkg::blen_t'(req.stb_cnt - 1'b1);
                  rd_left        <= '0;             // handed to the drain
                  state          <= ST_WR_CMD;
               end
            end
            ST_RD_FIFO: begin
               if ((rd_left == '0) && req.cyc && (owed || req.stb)) begin
                  // burst used up, fetch the next one without invalidation
                  p0_cmd_instr_o <= mem_pkg::MCB_RD_AP;
                  p0_cmd_bl_o    <= RD_BLEN;
                  p0_cmd_addr_o  <= adr_next;
                  rd_left        <= RD_WORDS;
                  state          <= ST_RD_CMD;
               end else if (rd.deliver) begin
                  rd_left  <= rd_left - 1'b1;
                  adr_next <= adr_next + mem_pkg::ADDR_STEP;
               end else if (!req.cyc) begin
                  state <= ST_IDLE;                 // leftovers stay as read-ahead
               end
            end
            ST_RD_CMD: begin
               if (cmd_issue) begin
                  state <= ST_RD_FIFO;
               end
            end
            default: state <= ST_RST;
         endcase
      end
   end

   // the wait states are the only way past a full cmd fifo
   cmd_not_full_a : assert property (@(posedge wb_clk) disable iff (mem_rst)
      p0_cmd_full_i |-> !p0_cmd_en_o)
      else $error("command issued while command fifo full");

endmodule

// ==== hw/mem_pkg.sv ====
package mem_pkg;

   //////////////////////////////////////////////////
   // widths shared by the wishbone side and port 0
   //////////////////////////////////////////////////

   typedef logic [28:0] addr_t;   // byte address, 512 Mbyte space
   typedef logic [31:0] dword_t;  // one data word
   typedef logic [3:0]  sel_t;    // byte select, inverted it is the write mask
   typedef logic [5:0]  blen_t;   // burst length minus one
   typedef logic [6:0]  cnt_t;    // strobe / ack / fifo word count

   //////////////////////////////////////////////////
   // controller instructions
   //////////////////////////////////////////////////

   // only the autoprecharge forms are issued on port 0
   typedef enum logic [2:0] {
      MCB_WR_AP = 3'b010,         // write with autoprecharge
      MCB_RD_AP = 3'b011          // read with autoprecharge
   } mcb_instr_e;

   // bytes per word, step of adr_next on every delivered word
   localparam addr_t ADDR_STEP = 29'd4;

endpackage

// ==== hw/rd_ctl_if.sv ====
`timescale 1ns/1ps

// read delivery and invalidation between execute and result
interface rd_ctl_if;

   logic          deliver;   // pop one word towards wishbone
   logic          inv_load;  // start a drain of inv_val stale words
   mem_pkg::cnt_t inv_val;
   logic          invld;     // drain running, plus one cycle for the empty flag
   mem_pkg::cnt_t ack_cnt;   // read acks given in this cycle

   modport seq (output deliver, inv_load, inv_val, input invld, ack_cnt);
   modport ret (input deliver, inv_load, inv_val, output invld, ack_cnt);

endinterface

// ==== hw/read_return.sv ====
`timescale 1ns/1ps

module read_return (
   input  logic            wb_clk,
   input  logic            mem_rst,
   input  logic            p0_rd_empty_i,
   input  mem_pkg::dword_t p0_rd_data_i,
   wb_req_if.dec           req,          // acc, we and clr_cnt only
   output logic            p0_rd_en_o,
   output logic            wbm_ack_o,
   output mem_pkg::dword_t wbm_dat_o,
   rd_ctl_if.ret           rd
);

   mem_pkg::cnt_t drain_cnt;    // stale words still to throw away
   logic          drain_nz_d;   // covers the empty flag lag after the last pop
   logic          drain_pop;
   mem_pkg::cnt_t ack_cnt;

   // drain only when nothing is delivered and a word is there
   assign drain_pop  = ~rd.deliver & (drain_cnt != '0) & ~p0_rd_empty_i;
   assign p0_rd_en_o = rd.deliver | drain_pop;
   assign rd.invld   = (drain_cnt != '0) | drain_nz_d;
   assign rd.ack_cnt = ack_cnt;

   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         drain_cnt  <= '0;
         drain_nz_d <= 1'b0;
         wbm_ack_o  <= 1'b0;
         ack_cnt    <= '0;
      end else begin
         drain_nz_d <= drain_cnt != '0;
         if (rd.inv_load) begin
            drain_cnt <= rd.inv_val;
         end else if (drain_pop) begin
            drain_cnt <= drain_cnt - 1'b1;
         end
         wbm_ack_o <= (req.acc & req.we) | rd.deliver;   // write ack or read word
         if (req.clr_cnt) begin
            ack_cnt <= mem_pkg::cnt_t'(rd.deliver);
         end else if (rd.deliver) begin
            ack_cnt <= ack_cnt + 1'b1;
         end
      end
   end

   // read word, captured as it leaves the fifo
   always_ff @(posedge wb_clk) begin
      if (rd.deliver) begin
         wbm_dat_o <= p0_rd_data_i;
      end
   end

   rd_pop_not_empty_a : assert property (@(posedge wb_clk) disable iff (mem_rst)
      p0_rd_en_o |-> !p0_rd_empty_i)
      else $error("read fifo popped while empty");

endmodule

// ==== hw/wb_decode.sv ====
`timescale 1ns/1ps

module wb_decode (
   input  logic           wb_clk,
   input  logic           mem_rst,
   input  logic           wbm_cyc_i,
   input  logic           wbm_stb_i,
   input  logic           wbm_we_i,
   input  mem_pkg::addr_t wbm_addr_i,
   input  logic           p0_wr_full_i,
   input  logic           p0_cmd_full_i,
   output logic           wbm_stall_o,
   output logic           p0_wr_en_o,
   wb_req_if.dec          req
);

   mem_pkg::cnt_t stb_cnt;   // accepted strobes since the fsm last cleared

   // stall on any full fifo of port 0, no other back-pressure
   assign wbm_stall_o = p0_wr_full_i | p0_cmd_full_i;
   assign req.acc     = wbm_cyc_i & wbm_stb_i & ~wbm_stall_o;
   assign p0_wr_en_o  = req.acc & wbm_we_i;    // word goes in with its strobe

   assign req.we      = wbm_we_i;
   assign req.addr    = wbm_addr_i;
   assign req.cyc     = wbm_cyc_i;
   assign req.stb     = wbm_stb_i;
   assign req.stb_cnt = stb_cnt;

   // first strobe after a clear counts as 1
   always_ff @(posedge wb_clk) begin
      if (mem_rst) begin
         stb_cnt <= '0;
      end else if (req.clr_cnt) begin
         stb_cnt <= mem_pkg::cnt_t'(req.acc);
      end else if (req.acc) begin
         stb_cnt <= stb_cnt + 1'b1;
      end
   end

   wr_en_not_stalled_a : assert property (@(posedge wb_clk) disable iff (mem_rst)
      p0_wr_en_o |-> !wbm_stall_o)
      else $error("write fifo enable while stalled");

endmodule

// ==== hw/wb_mem_port.sv ====
`timescale 1ns/1ps

module wb_mem_port #(
   parameter int READ_BURST_LEN = 8
) (
   input  logic                wb_clk,
   input  logic                mem_rst,
   // wishbone, pipelined block transfers
   input  logic                wbm_cyc_i,
   input  logic                wbm_stb_i,
   input  logic                wbm_we_i,
   input  mem_pkg::sel_t       wbm_sel_i,
   input  mem_pkg::addr_t      wbm_addr_i,
   input  mem_pkg::dword_t     wbm_dat_i,
   output logic                wbm_ack_o,
   output logic                wbm_stall_o,
   output mem_pkg::dword_t     wbm_dat_o,
   // port 0 command fifo
   output logic                p0_cmd_en_o,
   output mem_pkg::mcb_instr_e p0_cmd_instr_o,
   output mem_pkg::blen_t      p0_cmd_bl_o,
   output mem_pkg::addr_t      p0_cmd_addr_o,
   input  logic                p0_cmd_full_i,
   // port 0 write fifo
   output logic                p0_wr_en_o,
   output mem_pkg::sel_t       p0_wr_mask_o,
   output mem_pkg::dword_t     p0_wr_data_o,
   input  logic                p0_wr_full_i,
   // port 0 read fifo, first word visible while not empty
   output logic                p0_rd_en_o,
   input  mem_pkg::dword_t     p0_rd_data_i,
   input  logic                p0_rd_empty_i
);

   wb_req_if req_bus ();
   rd_ctl_if rd_bus ();

   assign p0_wr_mask_o = ~wbm_sel_i;   // controller masks out set bits
   assign p0_wr_data_o = wbm_dat_i;

   wb_decode u_decode (
      .wb_clk        (wb_clk),
      .mem_rst       (mem_rst),
      .wbm_cyc_i     (wbm_cyc_i),
      .wbm_stb_i     (wbm_stb_i),
      .wbm_we_i      (wbm_we_i),
      .wbm_addr_i    (wbm_addr_i),
      .p0_wr_full_i  (p0_wr_full_i),
      .p0_cmd_full_i (p0_cmd_full_i),
      .wbm_stall_o   (wbm_stall_o),
      .p0_wr_en_o    (p0_wr_en_o),
      .req           (req_bus)
   );

   burst_sequencer #(
      .READ_BURST_LEN (READ_BURST_LEN)
   ) u_seq (
      .wb_clk         (wb_clk),
      .mem_rst        (mem_rst),
      .p0_rd_empty_i  (p0_rd_empty_i),
      .p0_cmd_full_i  (p0_cmd_full_i),
      .p0_wr_full_i   (p0_wr_full_i),
      .p0_cmd_en_o    (p0_cmd_en_o),
      .p0_cmd_instr_o (p0_cmd_instr_o),
      .p0_cmd_bl_o    (p0_cmd_bl_o),
      .p0_cmd_addr_o  (p0_cmd_addr_o),
      .req            (req_bus),
      .rd             (rd_bus)
   );

   read_return u_ret (
      .wb_clk        (wb_clk),
      .mem_rst       (mem_rst),
      .p0_rd_empty_i (p0_rd_empty_i),
      .p0_rd_data_i  (p0_rd_data_i),
      .req           (req_bus),
      .p0_rd_en_o    (p0_rd_en_o),
      .wbm_ack_o     (wbm_ack_o),
      .wbm_dat_o     (wbm_dat_o),
      .rd            (rd_bus)
   );

endmodule

// ==== hw/wb_req_if.sv ====
`timescale 1ns/1ps

// accepted wishbone requests, decode to execute
interface wb_req_if;

   logic           acc;      // cyc & stb & ~stall
   logic           we;
   mem_pkg::addr_t addr;
   logic           cyc;
   logic           stb;      // raw strobe, also when stalled
   mem_pkg::cnt_t  stb_cnt;  // accepted strobes in this block transfer
   logic           clr_cnt;  // from the fsm, holds the counters at zero

   modport dec (output acc, we, addr, cyc, stb, stb_cnt, input clr_cnt);
   modport seq (input acc, we, addr, cyc, stb, stb_cnt, output clr_cnt);

endinterface

// ==== run.sh ====
#!/usr/bin/env bash
# compile with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_mem_port -f vlog.f -o sim_tb \
   && ./obj_dir/sim_tb | tee /dev/stderr | grep -x "TEST PASS" > /dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed" >&2; exit 1; }

// ==== tests/mcb_port_model.sv ====
`timescale 1ns/1ps

// port 0 of the sdram controller, behavioral, runs one command every few cycles
module mcb_port_model (
   input  logic                wb_clk,
   input  logic                mem_rst,
   input  logic                cmd_en_i,
   input  mem_pkg::mcb_instr_e cmd_instr_i,
   input  mem_pkg::blen_t      cmd_bl_i,
   input  mem_pkg::addr_t      cmd_addr_i,
   output logic                cmd_full_o,
   input  logic                wr_en_i,
   input  mem_pkg::sel_t       wr_mask_i,
   input  mem_pkg::dword_t     wr_data_i,
   output logic                wr_full_o,
   input  logic                rd_en_i,
   output mem_pkg::dword_t     rd_data_o,
   output logic                rd_empty_o
);

   mem_pkg::dword_t mem [4096];       // filled by the testbench at time 0
   logic [37:0]     cmd_q [$];        // {instr, bl, addr}
   logic [35:0]     wr_q [$];         // {mask, data}, 64 deep
   mem_pkg::dword_t rd_q [$];
   int              busy = 0;         // cycles until the next command runs

   initial begin
      cmd_full_o <= 1'b0;
      wr_full_o  <= 1'b0;
      rd_empty_o <= 1'b1;
      rd_data_o  <= '0;
   end

   always @(posedge wb_clk) begin
      logic [37:0] cmd;
      logic [35:0] w;
      logic [11:0] idx;
      if (mem_rst) begin
         cmd_q.delete();
         wr_q.delete();
         rd_q.delete();
         cmd_full_o <= 1'b0;
         wr_full_o  <= 1'b0;
      end else begin
         if (wr_en_i) wr_q.push_back({wr_mask_i, wr_data_i});
         if (cmd_en_i) cmd_q.push_back({cmd_instr_i, cmd_bl_i, cmd_addr_i});
         if (rd_en_i && rd_q.size() != 0) void'(rd_q.pop_front());
         if (busy > 0) begin
            busy--;
         end else if (cmd_q.size() != 0) begin
            cmd = cmd_q.pop_front();
            idx = cmd[13:2];                    // word index, wraps at 16 kbyte
            for (int i = 0; i <= int'(cmd[34:29]); i++) begin
               if (cmd[37:35] == mem_pkg::MCB_WR_AP) begin
                  w = (wr_q.size() != 0) ? wr_q.pop_front() : '1;
                  for (int b = 0; b < 4; b++) begin
                     if (!w[32 + b]) mem[idx][8*b +: 8] = w[8*b +: 8];  // mask bit set, keep
                  end
               end else begin
                  rd_q.push_back(mem[idx]);
               end
               idx++;
            end
            busy = 1 + $urandom_range(3);
         end
         // real fullness or a random hiccup, 1 in 8
         cmd_full_o <= (cmd_q.size() >= 4) || ($urandom_range(7) == 0);
         wr_full_o  <= (wr_q.size() >= 64) || ($urandom_range(7) == 0);
      end
      rd_empty_o <= (rd_q.size() == 0);
      rd_data_o  <= (rd_q.size() != 0) ? rd_q[0] : '0;   // first word falls through
   end

endmodule

// ==== tests/tb_wb_mem_port.sv ====
`timescale 1ns/1ps

module tb_wb_mem_port;

   localparam int    READ_BURST_LEN = 8;
   localparam int    N_RAND         = 24;
   localparam int    N_XFERS        = 12 + N_RAND;        // directed plus random
   localparam longint WATCHDOG_NS   = N_XFERS * 200_000 + 100_000;

   logic                wb_clk     = 1'b0;
   logic                mem_rst    = 1'b1;
   logic                wbm_cyc_i  = 1'b0;
   logic                wbm_stb_i  = 1'b0;
   logic                wbm_we_i   = 1'b0;
   mem_pkg::sel_t       wbm_sel_i  = '0;
   mem_pkg::addr_t      wbm_addr_i = '0;
   mem_pkg::dword_t     wbm_dat_i  = '0;
   logic                wbm_ack_o, wbm_stall_o;
   mem_pkg::dword_t     wbm_dat_o;
   logic                p0_cmd_en_o, p0_cmd_full_i, p0_wr_en_o, p0_wr_full_i;
   mem_pkg::mcb_instr_e p0_cmd_instr_o;
   mem_pkg::blen_t      p0_cmd_bl_o;
   mem_pkg::addr_t      p0_cmd_addr_o;
   mem_pkg::sel_t       p0_wr_mask_o;
   mem_pkg::dword_t     p0_wr_data_o, p0_rd_data_i;
   logic                p0_rd_en_o, p0_rd_empty_i;

   mem_pkg::dword_t shadow [4096];           // what memory should hold
   mem_pkg::dword_t exp_q [$];               // read words still owed, in order
   mem_pkg::dword_t got_dat, exp_dat;
   mem_pkg::addr_t  wr_first = '0;           // first address since the last write command
   int              wr_words = 0;            // write words since the last write command
   int              errors = 0, words_wr = 0, words_rd = 0;
   logic            wr_phase = 1'b0, rd_phase = 1'b0, seen_stb = 1'b0, rst_seen = 1'b0;
   logic            chk_dat = 1'b0, extra_ack = 1'b0;
   logic            wr_acc, wr_cmd;

   always #50 wb_clk = ~wb_clk;

   wb_mem_port #(.READ_BURST_LEN(READ_BURST_LEN)) u_dut (.*);

   mcb_port_model u_model (
      .wb_clk (wb_clk), .mem_rst (mem_rst),
      .cmd_en_i (p0_cmd_en_o), .cmd_instr_i (p0_cmd_instr_o), .cmd_bl_i (p0_cmd_bl_o),
      .cmd_addr_i (p0_cmd_addr_o), .cmd_full_o (p0_cmd_full_i),
      .wr_en_i (p0_wr_en_o), .wr_mask_i (p0_wr_mask_o), .wr_data_i (p0_wr_data_o),
      .wr_full_o (p0_wr_full_i),
      .rd_en_i (p0_rd_en_o), .rd_data_o (p0_rd_data_i), .rd_empty_o (p0_rd_empty_i)
   );

   assign wr_acc = wbm_cyc_i & wbm_stb_i & wbm_we_i & ~wbm_stall_o;
   assign wr_cmd = p0_cmd_en_o & (p0_cmd_instr_o == mem_pkg::MCB_WR_AP);

   task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      errors++;
      $display("CHECK FAILED %s got %h exp %h at %0t", name, got, exp, $time);
   endtask

   task automatic report_text(input string what);
      errors++;
      $display("error at %0t: %s", $time, what);
   endtask

   //////////////////////////////////////////////////
   // bookkeeping for the assertions
   //////////////////////////////////////////////////

   always @(posedge wb_clk) begin
      rst_seen <= rst_seen | mem_rst;
      if (wr_cmd) wr_words <= int'(p0_wr_en_o);       // a word in the command cycle is the next burst
      else if (p0_wr_en_o) wr_words <= wr_words + 1;
      if (p0_wr_en_o && (wr_words == 0 || wr_cmd)) wr_first <= wbm_addr_i;
      chk_dat   <= wbm_ack_o && rd_phase && exp_q.size() != 0;
      extra_ack <= wbm_ack_o && rd_phase && exp_q.size() == 0;
      if (wbm_ack_o && rd_phase && exp_q.size() != 0) begin
         got_dat <= wbm_dat_o;
         exp_dat <= exp_q.pop_front();
      end
   end

   //////////////////////////////////////////////////
   // checks
   //////////////////////////////////////////////////

   quiet_a : assert property (@(posedge wb_clk) rst_seen && !seen_stb |->
      !(wbm_ack_o || p0_cmd_en_o || p0_wr_en_o || p0_rd_en_o))
      else report_text("ack or controller enable active before the first strobe");
   wr_ack_a : assert property (@(posedge wb_clk) disable iff (mem_rst) wr_acc |=> wbm_ack_o)
      else report_value("wbm_ack_o", 0, 1);
   ack_src_a : assert property (@(posedge wb_clk) disable iff (mem_rst)
      wbm_ack_o && wr_phase |-> $past(wr_acc))
      else report_text("write ack without a write strobe the cycle before");
   ack_idle_a : assert property (@(posedge wb_clk) disable iff (mem_rst) !wbm_cyc_i |-> !wbm_ack_o)
      else report_text("ack outside a bus cycle");
   wr_bl_a : assert property (@(posedge wb_clk) disable iff (mem_rst)
      wr_cmd |-> p0_cmd_bl_o == mem_pkg::blen_t'(wr_words - 1))
      else report_value("p0_cmd_bl_o", $sampled(p0_cmd_bl_o), $sampled(wr_words) - 1);
   wr_addr_a : assert property (@(posedge wb_clk) disable iff (mem_rst)
      wr_cmd |-> p0_cmd_addr_o == wr_first)
      else report_value("p0_cmd_addr_o", $sampled(p0_cmd_addr_o), $sampled(wr_first));
   rd_bl_a : assert property (@(posedge wb_clk) disable iff (mem_rst)
      p0_cmd_en_o && !wr_cmd |-> p0_cmd_bl_o == mem_pkg::blen_t'(READ_BURST_LEN - 1))
      else report_value("p0_cmd_bl_o", $sampled(p0_cmd_bl_o), READ_BURST_LEN - 1);
   rd_dat_a : assert property (@(posedge wb_clk) chk_dat |-> got_dat == exp_dat)
      else report_value("wbm_dat_o", $sampled(got_dat), $sampled(exp_dat));
   extra_ack_a : assert property (@(posedge wb_clk) !extra_ack)
      else report_text("read ack with no strobe outstanding");
   stall_a : assert property (@(posedge wb_clk) disable iff (mem_rst)
      wbm_stall_o == (p0_cmd_full_i || p0_wr_full_i))
      else report_value("wbm_stall_o", $sampled(wbm_stall_o),
                        $sampled(p0_cmd_full_i || p0_wr_full_i));
   wr_stall_a : assert property (@(posedge wb_clk) disable iff (mem_rst) p0_wr_en_o |-> !wbm_stall_o)
      else report_text("write fifo enable while stalled");
   cmd_full_a : assert property (@(posedge wb_clk) disable iff (mem_rst)
      p0_cmd_en_o |-> !p0_cmd_full_i)
      else report_text("command issued into a full command fifo");

   // one pipelined block transfer, strobes run ahead of the acks
   task automatic block_xfer(input logic wr, input int word, input int n, input mem_pkg::sel_t sel);
      int          sent;
      int          acks;
      logic [11:0] idx;
      sent = 0;
      acks = 0;
      @(posedge wb_clk);
      {wr_phase, rd_phase, seen_stb} <= {wr, !wr, 1'b1};
      {wbm_cyc_i, wbm_stb_i, wbm_we_i} <= {2'b11, wr};
      wbm_sel_i  <= sel;
      wbm_addr_i <= mem_pkg::addr_t'(word * 4);
      wbm_dat_i  <= $urandom;
      while (acks < n) begin
         @(posedge wb_clk);
         acks += int'(wbm_ack_o);
         if (wbm_stb_i && !wbm_stall_o) begin                // accepted at this edge
            idx = wbm_addr_i[13:2];
            if (wr) begin
               for (int b = 0; b < 4; b++) begin
                  if (sel[b]) shadow[idx][8*b +: 8] = wbm_dat_i[8*b +: 8];
               end
               words_wr++;
            end else begin
               exp_q.push_back(shadow[idx]);
               words_rd++;
            end
            sent++;
            wbm_stb_i  <= sent < n;
            wbm_addr_i <= wbm_addr_i + 29'd4;
            wbm_dat_i  <= $urandom;
         end
      end
      {wbm_cyc_i, wbm_stb_i, wr_phase, rd_phase} <= 4'b0000;
      repeat (2) @(posedge wb_clk);
   endtask

   initial begin
      void'($urandom(32'h740ef2bb));
      for (int i = 0; i < 4096; i++) begin
         shadow[i]      = {i[11:0], 8'h5a, ~i[11:0]};     // unique per word address
         u_model.mem[i] = shadow[i];
      end
      repeat (16) @(posedge wb_clk);
      mem_rst <= 1'b0;
      repeat (4) @(posedge wb_clk);
      block_xfer(1'b0, 'h040, 3, 4'hf);                   // shorter than a burst
      block_xfer(1'b0, 'h080, READ_BURST_LEN, 4'hf);
      block_xfer(1'b0, 'h0c0, 13, 4'hf);                  // longer, needs a second burst
      block_xfer(1'b0, 'h100, 5, 4'hf);
      block_xfer(1'b0, 'h105, 6, 4'hf);                   // continues, read-ahead
      block_xfer(1'b0, 'h300, 4, 4'hf);                   // unrelated, invalidation
      block_xfer(1'b1, 'h100, 6, 4'hf);
      block_xfer(1'b0, 'h100, 6, 4'hf);                   // sees the new data
      block_xfer(1'b1, 'h101, 3, 4'b0101);                // partial bytes
      block_xfer(1'b0, 'h100, 8, 4'hf);
      block_xfer(1'b1, 'h200, 12, 4'hf);
      block_xfer(1'b0, 'h200, 12, 4'hf);
      repeat (N_RAND) begin
         block_xfer(1'($urandom_range(1)), int'($urandom_range(4095)),
                    1 + int'($urandom_range(15)), mem_pkg::sel_t'($urandom));
      end
      repeat (20) @(posedge wb_clk);
      $display("errors %0d, words written %0d, words read %0d", errors, words_wr, words_rd);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired, a transfer never completed");
      $display("errors %0d, words written %0d, words read %0d", errors, words_wr, words_rd);
      $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== vlog.f ====
hw/mem_pkg.sv
hw/wb_req_if.sv
hw/rd_ctl_if.sv
hw/wb_decode.sv
hw/burst_sequencer.sv
hw/read_return.sv
hw/wb_mem_port.sv
tests/mcb_port_model.sv
tests/tb_wb_mem_port.sv
